// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // supported instructions; inst_invalid marks anything the decoder rejects
  typedef enum logic [5:0] {
    inst_invalid,
    inst_lui, inst_auipc, inst_jal, inst_jalr,
    inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu,
    inst_lb, inst_lh, inst_lw, inst_ld, inst_lbu, inst_lhu, inst_lwu,
    inst_sb, inst_sh, inst_sw, inst_sd,
    inst_addi, inst_slti, inst_sltiu, inst_xori, inst_ori, inst_andi,
    inst_slli, inst_srli, inst_srai,
    inst_addiw, inst_slliw, inst_srliw, inst_sraiw,
    inst_add, inst_sub, inst_sll, inst_slt, inst_sltu,
    inst_xor, inst_srl, inst_sra, inst_or, inst_and,
    inst_addw, inst_subw, inst_sllw, inst_srlw, inst_sraw,
    inst_ebreak
  } inst_e;

  // major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_imm32  = 7'b0011011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_reg32  = 7'b0111011;
  localparam logic [6:0] op_system = 7'b1110011;

  // funct3 for alu ops
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_srl  = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // funct3 for branches
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // funct3 access widths for loads and stores
  localparam logic [2:0] f3_b  = 3'b000;
  localparam logic [2:0] f3_h  = 3'b001;
  localparam logic [2:0] f3_w  = 3'b010;
  localparam logic [2:0] f3_d  = 3'b011;
  localparam logic [2:0] f3_bu = 3'b100;
  localparam logic [2:0] f3_hu = 3'b101;
  localparam logic [2:0] f3_wu = 3'b110;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  localparam logic [31:0] ebreak_word = 32'h00100073;

endpackage

// ==== rtl/core_cfg_pkg.sv ====
package core_cfg_pkg;

  // decoder output, one per instruction
  typedef struct packed {
    rv_isa_pkg::inst_e op;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [4:0]        rd;
    logic [63:0]       imm;
    logic              rd_we;
  } decoded_t;

  // data memory request
  // wmask and wdata are already placed on the doubleword lanes
  typedef struct packed {
    logic [63:0] addr;
    logic        we;
    logic [7:0]  wmask;
    logic [63:0] wdata;
  } mem_req_t;

  // one retired instruction
  typedef struct packed {
    logic [63:0] pc;
    logic [4:0]  rd;
    logic        rd_we;
    logic [63:0] wdata;
  } retire_t;

endpackage

// ==== rtl/idu.sv ====
`timescale 1ns/1ns

module idu (
  input  logic [31:0]           inst,
  output core_cfg_pkg::decoded_t dec
);
  import rv_isa_pkg::*;

  logic [6:0]  opcode;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [63:0] imm_i;
  logic [63:0] imm_s;
  logic [63:0] imm_b;
  logic [63:0] imm_u;
  logic [63:0] imm_j;
  inst_e       op;
  logic [63:0] imm;
  logic        writes_rd;

  assign opcode = inst[6:0];
  assign f3     = inst[14:12];
  assign f7     = inst[31:25];

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};
  assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    op        = inst_invalid;
    imm       = imm_i;
    writes_rd = 1'b1;
    unique case (opcode)
      op_lui:   begin op = inst_lui;   imm = imm_u; end
      op_auipc: begin op = inst_auipc; imm = imm_u; end
      op_jal:   begin op = inst_jal;   imm = imm_j; end
      op_jalr:  op = (f3 == 3'b000) ? inst_jalr : inst_invalid;
      op_branch: begin
        imm       = imm_b;
        writes_rd = 1'b0;
        unique case (f3)
          f3_beq:  op = inst_beq;
          f3_bne:  op = inst_bne;
          f3_blt:  op = inst_blt;
          f3_bge:  op = inst_bge;
          f3_bltu: op = inst_bltu;
          f3_bgeu: op = inst_bgeu;
          default: op = inst_invalid;
        endcase
      end
      op_load: begin
        unique case (f3)
          f3_b:    op = inst_lb;
          f3_h:    op = inst_lh;
          f3_w:    op = inst_lw;
          f3_d:    op = inst_ld;
          f3_bu:   op = inst_lbu;
          f3_hu:   op = inst_lhu;
          f3_wu:   op = inst_lwu;
          default: op = inst_invalid;
        endcase
      end
      op_store: begin
        imm       = imm_s;
        writes_rd = 1'b0;
        unique case (f3)
          f3_b:    op = inst_sb;
          f3_h:    op = inst_sh;
          f3_w:    op = inst_sw;
          f3_d:    op = inst_sd;
          default: op = inst_invalid;
        endcase
      end
      op_imm: begin
        unique case (f3)
          f3_add:  op = inst_addi;
          f3_slt:  op = inst_slti;
          f3_sltu: op = inst_sltiu;
          f3_xor:  op = inst_xori;
          f3_or:   op = inst_ori;
          f3_and:  op = inst_andi;
          // rv64 shifts take a 6-bit shamt, so only funct6 is fixed
          f3_sll:  op = (f7[6:1] == f7_base[6:1]) ? inst_slli : inst_invalid;
          f3_srl: begin
            if (f7[6:1] == f7_base[6:1]) op = inst_srli;
            else if (f7[6:1] == f7_alt[6:1]) op = inst_srai;
          end
          default: op = inst_invalid;
        endcase
      end
      op_imm32: begin
        unique case ({f7, f3})
          {f7_base, f3_sll}: op = inst_slliw;
          {f7_base, f3_srl}: op = inst_srliw;
          {f7_alt, f3_srl}:  op = inst_sraiw;
          default:           op = (f3 == f3_add) ? inst_addiw : inst_invalid;
        endcase
      end
      op_reg: begin
        unique case ({f7, f3})
          {f7_base, f3_add}:  op = inst_add;
          {f7_alt, f3_add}:   op = inst_sub;
          {f7_base, f3_sll}:  op = inst_sll;
          {f7_base, f3_slt}:  op = inst_slt;
          {f7_base, f3_sltu}: op = inst_sltu;
          {f7_base, f3_xor}:  op = inst_xor;
          {f7_base, f3_srl}:  op = inst_srl;
          {f7_alt, f3_srl}:   op = inst_sra;
          {f7_base, f3_or}:   op = inst_or;
          {f7_base, f3_and}:  op = inst_and;
          default:            op = inst_invalid;
        endcase
      end
      op_reg32: begin
        unique case ({f7, f3})
          {f7_base, f3_add}: op = inst_addw;
          {f7_alt, f3_add}:  op = inst_subw;
          {f7_base, f3_sll}: op = inst_sllw;
          {f7_base, f3_srl}: op = inst_srlw;
          {f7_alt, f3_srl}:  op = inst_sraw;
          default:           op = inst_invalid;
        endcase
      end
      op_system: begin
        writes_rd = 1'b0;
        op        = (inst == ebreak_word) ? inst_ebreak : inst_invalid;
      end
      default: op = inst_invalid;
    endcase
  end

  always_comb begin
    dec.op    = op;
    dec.rs1   = inst[19:15];
    dec.rs2   = inst[24:20];
    dec.rd    = inst[11:7];
    dec.imm   = imm;
    // x0 writes are dropped here so retire records show no write
    dec.rd_we = writes_rd && (op != inst_invalid) && (inst[11:7] != 5'd0);
  end

endmodule

// ==== rtl/regfile.sv ====
`timescale 1ns/1ns

module regfile (
  input  logic        clk,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        we,
  input  logic [63:0] wdata,
  output logic [63:0] rdata1,
  output logic [63:0] rdata2
);

  logic [63:0] regs [32];

  // x0 never stored, reads are forced to zero below
  always_ff @(posedge clk) begin
    if (we && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = (rs1 == 5'd0) ? 64'd0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? 64'd0 : regs[rs2];

endmodule

// ==== rtl/exu.sv ====
`timescale 1ns/1ns

module exu (
  input  core_cfg_pkg::decoded_t dec,
  input  logic [63:0]            src1,
  input  logic [63:0]            src2,
  input  logic [63:0]            pc,
  input  logic [63:0]            mem_rdata,
  output core_cfg_pkg::mem_req_t mem_req,
  output logic [63:0]            result,
  output logic [63:0]            dnpc
);
  import rv_isa_pkg::*;

  logic [63:0] opb;
  logic [63:0] addr;
  logic [63:0] link;
  logic [63:0] ld_data;
  logic [5:0]  shamt;
  logic [4:0]  shamt_w;
  logic [31:0] word;
  logic [7:0]  base_mask;
  logic [15:0] mask_wide;
  logic        is_store;
  logic        taken;

  // register forms take src2, everything else the immediate
  assign opb = (dec.op inside {inst_add, inst_sub, inst_sll, inst_slt, inst_sltu,
                               inst_xor, inst_srl, inst_sra, inst_or, inst_and,
                               inst_addw, inst_subw, inst_sllw, inst_srlw,
                               inst_sraw}) ? src2 : dec.imm;

  assign shamt   = opb[5:0];
  assign shamt_w = opb[4:0];
  assign addr    = src1 + dec.imm;
  assign link    = pc + 64'd4;

  // load lane moved down to bit 0
  assign ld_data = mem_rdata >> {addr[2:0], 3'b000};

  // 32-bit word ops, sign-extended later
  always_comb begin
    unique case (dec.op)
      inst_addw, inst_addiw: word = src1[31:0] + opb[31:0];
      inst_subw:             word = src1[31:0] - opb[31:0];
      inst_sllw, inst_slliw: word = src1[31:0] << shamt_w;
      inst_srlw, inst_srliw: word = src1[31:0] >> shamt_w;
      inst_sraw, inst_sraiw: word = $signed(src1[31:0]) >>> shamt_w;
      default:               word = 32'd0;
    endcase
  end

  always_comb begin
    unique case (dec.op)
      inst_lui:                result = dec.imm;
      inst_auipc:              result = pc + dec.imm;
      inst_jal, inst_jalr:     result = link;
      inst_add, inst_addi:     result = src1 + opb;
      inst_sub:                result = src1 - opb;
      inst_sll, inst_slli:     result = src1 << shamt;
      inst_srl, inst_srli:     result = src1 >> shamt;
      inst_sra, inst_srai:     result = $signed(src1) >>> shamt;
      inst_slt, inst_slti:     result = {63'd0, $signed(src1) < $signed(opb)};
      inst_sltu, inst_sltiu:   result = {63'd0, src1 < opb};
      inst_xor, inst_xori:     result = src1 ^ opb;
      inst_or, inst_ori:       result = src1 | opb;
      inst_and, inst_andi:     result = src1 & opb;
      inst_addw, inst_addiw, inst_subw, inst_sllw, inst_slliw,
      inst_srlw, inst_srliw, inst_sraw, inst_sraiw:
        result = {{32{word[31]}}, word};
      inst_lb:  result = {{56{ld_data[7]}}, ld_data[7:0]};
      inst_lbu: result = {56'd0, ld_data[7:0]};
      inst_lh:  result = {{48{ld_data[15]}}, ld_data[15:0]};
      inst_lhu: result = {48'd0, ld_data[15:0]};
      inst_lw:  result = {{32{ld_data[31]}}, ld_data[31:0]};
      inst_lwu: result = {32'd0, ld_data[31:0]};
      inst_ld:  result = ld_data;
      default:  result = 64'd0;
    endcase
  end

  always_comb begin
    unique case (dec.op)
      inst_beq:  taken = (src1 == src2);
      inst_bne:  taken = (src1 != src2);
      inst_blt:  taken = ($signed(src1) < $signed(src2));
      inst_bge:  taken = ($signed(src1) >= $signed(src2));
      inst_bltu: taken = (src1 < src2);
      inst_bgeu: taken = (src1 >= src2);
      default:   taken = 1'b0;
    endcase
  end

  always_comb begin
    if (dec.op == inst_jalr) begin
      dnpc = {addr[63:1], 1'b0};
    end else if (dec.op == inst_jal || taken) begin
      dnpc = pc + dec.imm;
    end else begin
      dnpc = link;
    end
  end

  // store lanes
  assign is_store = dec.op inside {inst_sb, inst_sh, inst_sw, inst_sd};

  always_comb begin
    unique case (dec.op)
      inst_sb: base_mask = 8'h01;
      inst_sh: base_mask = 8'h03;
      inst_sw: base_mask = 8'h0f;
      inst_sd: base_mask = 8'hff;
      default: base_mask = 8'h00;
    endcase
  end

  assign mask_wide = {8'h00, base_mask} << addr[2:0];

  always_comb begin
    mem_req.addr  = addr;
    mem_req.we    = is_store;
    mem_req.wmask = mask_wide[7:0];
    mem_req.wdata = src2 << {addr[2:0], 3'b000};
  end

  // bytes pushed past lane 7 would be silently lost
  always_comb begin
    if (is_store) begin
      assert (mask_wide[15:8] == 8'h00)
        else $error("store at %h crosses the doubleword", addr);
    end
  end

endmodule

// ==== rtl/data_mem.sv ====
`timescale 1ns/1ns

module data_mem #(
  parameter int dmem_words = 512
) (
  input  logic                   clk,
  input  core_cfg_pkg::mem_req_t req,
  output logic [63:0]            rdata
);

  localparam int idx_w = $clog2(dmem_words);

  logic [63:0]      mem [dmem_words];
  logic [idx_w-1:0] idx;

  // byte offset dropped, upper address bits wrap
  assign idx   = req.addr[idx_w+2:3];
  assign rdata = mem[idx];

  always_ff @(posedge clk) begin
    if (req.we) begin
      for (int i = 0; i < 8; i++) begin
        if (req.wmask[i]) begin
          mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
    end
  end

endmodule

// ==== rtl/core_top.sv ====
`timescale 1ns/1ns

module core_top #(
  parameter int imem_words = 256,
  parameter int dmem_words = 512
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          prog_we,
  input  logic [$clog2(imem_words)-1:0] prog_addr,
  input  logic [31:0]                   prog_data,
  input  logic                          run,
  output logic                          halted,
  output logic                          trap,
  output logic                          retire_valid,
  output core_cfg_pkg::retire_t         retire
);
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;

  localparam int iaw = $clog2(imem_words);

  logic [63:0] pc;
  logic [31:0] imem [imem_words];
  logic [31:0] inst;
  decoded_t    dec;
  logic [63:0] src1;
  logic [63:0] src2;
  logic [63:0] result;
  logic [63:0] dnpc;
  logic [63:0] mem_rdata;
  mem_req_t    exu_req;
  mem_req_t    dmem_req;
  logic        active;
  logic        stop;

  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;
    end
  end

  assign inst = imem[pc[iaw+1:2]];

  assign active       = run && !halted;
  // an invalid word halts the core but never retires
  assign retire_valid = active && (dec.op != inst_invalid);
  assign stop         = dec.op inside {inst_ebreak, inst_invalid};

  always_comb begin
    dmem_req    = exu_req;
    dmem_req.we = exu_req.we && retire_valid;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= 64'd0;
      halted <= 1'b0;
      trap   <= 1'b0;
    end else begin
      if (!run) begin
        pc <= 64'd0;
      end else if (retire_valid) begin
        pc <= dnpc;
      end
      if (active && stop) begin
        halted <= 1'b1;
        trap   <= (dec.op == inst_invalid);
      end
    end
  end

  always_comb begin
    retire.pc    = pc;
    retire.rd    = dec.rd;
    retire.rd_we = dec.rd_we;
    retire.wdata = result;
  end

  idu idu_i (
    .inst (inst),
    .dec  (dec)
  );

  regfile regfile_i (
    .clk    (clk),
    .rs1    (dec.rs1),
    .rs2    (dec.rs2),
    .rd     (dec.rd),
    .we     (retire_valid && dec.rd_we),
    .wdata  (result),
    .rdata1 (src1),
    .rdata2 (src2)
  );

  exu exu_i (
    .dec       (dec),
    .src1      (src1),
    .src2      (src2),
    .pc        (pc),
    .mem_rdata (mem_rdata),
    .mem_req   (exu_req),
    .result    (result),
    .dnpc      (dnpc)
  );

  data_mem #(
    .dmem_words (dmem_words)
  ) data_mem_i (
    .clk   (clk),
    .req   (dmem_req),
    .rdata (mem_rdata)
  );

  // jalr clears only bit 0 so a bad target shows up here
  pc_aligned: assert property (@(posedge clk) disable iff (rst)
    run |-> pc[1:0] == 2'b00);

endmodule

// ==== dv/tb_clk.sv ====
`timescale 1ns/1ns

module tb_clk #(
  parameter int period = 40
) (
  output logic clk
);

  // free-running, starts low
  initial begin
    clk = 1'b0;
    forever begin
      #(period / 2) clk = ~clk;
    end
  end

endmodule

// ==== dv/core_tb.sv ====
`timescale 1ns/1ns

module core_tb;
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;

  localparam int imem_words = 256;
  localparam int dmem_words = 512;
  localparam int max_cycles = 2000;

  logic        clk;
  logic        rst;
  logic        prog_we;
  logic [7:0]  prog_addr;
  logic [31:0] prog_data;
  logic        run;
  logic        halted;
  logic        trap;
  logic        retire_valid;
  retire_t     retire;

  // program image and instruction-set model state
  logic [31:0] prog [imem_words];
  int          prog_len;
  logic [63:0] xr [32];
  logic [7:0]  mmem [32];
  logic [63:0] mpc;
  logic [31:0] seed;

  tb_clk #(.period (40)) tb_clk_i (.clk (clk));

  core_top #(
    .imem_words (imem_words),
    .dmem_words (dmem_words)
  ) core_top_i (
    .clk          (clk),
    .rst          (rst),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .run          (run),
    .halted       (halted),
    .trap         (trap),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  function automatic logic [31:0] lcg();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // low bits of the lcg are weak, use the upper ones
  function automatic int unsigned pick(input int unsigned n);
    logic [31:0] r;
    r = lcg();
    return {8'd0, r[31:8]} % n;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  task automatic emit(input logic [31:0] w);
    prog[prog_len[7:0]] = w;
    prog_len++;
  endtask

  // prologue seeds x1..x30, x31 = 0x100 as the memory window base,
  // then the window gets four full doublewords
  task automatic gen_program(input bit with_init, input int body_len,
                             input logic [31:0] last_word);
    int          end_idx;
    int          k;
    int          off;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    prog_len = 0;
    if (with_init) begin
      for (int i = 1; i < 31; i++) begin
        emit(u_type(20'(lcg() >> 12), 5'(i), op_lui));
        emit(i_type(12'(lcg()), 5'(i), f3_add, 5'(i), op_imm));
      end
      emit(i_type(12'h100, 5'd0, f3_add, 5'd31, op_imm));
      for (int i = 0; i < 4; i++) begin
        emit(s_type(12'(8 * i), 5'(pick(30) + 1), 5'd31, f3_d));
      end
    end
    end_idx = prog_len + body_len;
    while (prog_len < end_idx) begin
      rd  = 5'(pick(31));
      rs1 = 5'(pick(32));
      rs2 = 5'(pick(32));
      f3  = 3'(pick(8));
      // forward target, never past the closing word
      k = 1 + int'(pick(4));
      if (prog_len + k > end_idx) k = end_idx - prog_len;
      case (pick(10))
        0: begin
          f7 = ((f3 == f3_add || f3 == f3_srl) && pick(2) == 1) ? f7_alt : f7_base;
          emit(r_type(f7, rs2, rs1, f3, rd, op_reg));
        end
        1: begin
          off = int'(pick(3));
          f3 = (off == 0) ? f3_add : ((off == 1) ? f3_sll : f3_srl);
          f7 = (f3 != f3_sll && pick(2) == 1) ? f7_alt : f7_base;
          emit(r_type(f7, rs2, rs1, f3, rd, op_reg32));
        end
        2: begin
          if (f3 == f3_sll) imm = {6'd0, 6'(pick(64))};
          else if (f3 == f3_srl) imm = {pick(2) == 1 ? 6'b010000 : 6'd0, 6'(pick(64))};
          else imm = 12'(lcg());
          emit(i_type(imm, rs1, f3, rd, op_imm));
        end
        3: begin
          off = int'(pick(3));
          f3 = (off == 0) ? f3_add : ((off == 1) ? f3_sll : f3_srl);
          f7 = (f3 == f3_srl && pick(2) == 1) ? f7_alt : f7_base;
          imm = (f3 == f3_add) ? 12'(lcg()) : {f7, 5'(pick(32))};
          emit(i_type(imm, rs1, f3, rd, op_imm32));
        end
        4: begin
          f3  = 3'(pick(4));
          off = int'(pick(32 >> f3) << f3);
          emit(s_type(12'(off), rs2, 5'd31, f3));
        end
        5: begin
          f3  = 3'(pick(7));
          off = int'(pick(32 >> f3[1:0]) << f3[1:0]);
          emit(i_type(12'(off), 5'd31, f3, rd, op_load));
        end
        6: begin
          // 0..5 onto beq bne blt bge bltu bgeu
          f3 = 3'(pick(6));
          if (f3 > 3'd1) f3 = f3 + 3'd2;
          if (pick(2) == 1) rs2 = rs1;
          emit(b_type(13'(4 * k), rs2, rs1, f3));
        end
        7: emit(j_type(21'(4 * k), rd));
        // odd absolute target, bit 0 must be dropped
        8: emit(i_type(12'(4 * (prog_len + k) + 1), 5'd0, 3'b000, rd, op_jalr));
        default: emit(u_type(20'(lcg()), rd, pick(2) == 1 ? op_lui : op_auipc));
      endcase
    end
    emit(last_word);
  endtask

  function automatic logic br_taken(input logic [2:0] f3, input logic [63:0] a,
                                    input logic [63:0] b);
    case (f3)
      f3_beq:  return a == b;
      f3_bne:  return a != b;
      f3_blt:  return $signed(a) < $signed(b);
      f3_bge:  return $signed(a) >= $signed(b);
      f3_bltu: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [63:0] alu(input logic [2:0] f3, input logic alt, input logic word,
                                      input logic [63:0] a, input logic [63:0] b);
    logic [63:0] r;
    logic [31:0] v;
    r = 64'd0;
    v = 32'd0;
    if (word) begin
      if (f3 == f3_sll) v = a[31:0] << b[4:0];
      else if (f3 == f3_srl && alt) v = $signed(a[31:0]) >>> b[4:0];
      else if (f3 == f3_srl) v = a[31:0] >> b[4:0];
      else if (alt) v = a[31:0] - b[31:0];
      else v = a[31:0] + b[31:0];
      r = {{32{v[31]}}, v};
    end else begin
      case (f3)
        f3_add:  r = alt ? a - b : a + b;
        f3_sll:  r = a << b[5:0];
        f3_slt:  r = {63'd0, $signed(a) < $signed(b)};
        f3_sltu: r = {63'd0, a < b};
        f3_xor:  r = a ^ b;
        f3_srl: begin
          if (alt) r = $signed(a) >>> b[5:0];
          else r = a >> b[5:0];
        end
        f3_or:   r = a | b;
        default: r = a & b;
      endcase
    end
    return r;
  endfunction

  // executes the word at mpc; memory window is 0x100..0x11f
  task automatic model_step(output logic exp_we, output logic [4:0] exp_rd,
                            output logic [63:0] exp_val, output logic ends);
    logic [31:0] w;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm_i;
    logic [63:0] addr;
    logic [63:0] npc;
    logic [63:0] ld;
    logic        alt;
    int          n;
    int          sh;
    w     = prog[mpc[9:2]];
    a     = xr[w[19:15]];
    b     = xr[w[24:20]];
    imm_i = {{52{w[31]}}, w[31:20]};
    alt   = w[30] && (w[6:0] == op_reg || w[6:0] == op_reg32 || w[14:12] == f3_srl);
    n     = 1 << w[13:12];
    exp_rd  = w[11:7];
    exp_we  = 1'b1;
    exp_val = 64'd0;
    ends    = 1'b0;
    npc     = mpc + 64'd4;
    case (w[6:0])
      op_lui:   exp_val = {{32{w[31]}}, w[31:12], 12'h000};
      op_auipc: exp_val = mpc + {{32{w[31]}}, w[31:12], 12'h000};
      op_jal: begin
        exp_val = mpc + 64'd4;
        npc = mpc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      op_jalr: begin
        exp_val = mpc + 64'd4;
        npc = (a + imm_i) & ~64'd1;
      end
      op_branch: begin
        exp_we = 1'b0;
        if (br_taken(w[14:12], a, b)) begin
          npc = mpc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      op_load: begin
        addr = a + imm_i;
        ld = 64'd0;
        for (int i = 0; i < 8; i++) begin
          if (i < n) ld[8*i +: 8] = mmem[addr[4:0] + i[4:0]];
        end
        if (!w[14]) begin
          sh = 64 - 8 * n;
          ld = ld << sh;
          ld = $signed(ld) >>> sh;
        end
        exp_val = ld;
      end
      op_store: begin
        exp_we = 1'b0;
        addr = a + {{52{w[31]}}, w[31:25], w[11:7]};
        for (int i = 0; i < 8; i++) begin
          if (i < n) mmem[addr[4:0] + i[4:0]] = b[8*i +: 8];
        end
      end
      op_imm:   exp_val = alu(w[14:12], alt, 1'b0, a, imm_i);
      op_imm32: exp_val = alu(w[14:12], alt, 1'b1, a, imm_i);
      op_reg:   exp_val = alu(w[14:12], alt, 1'b0, a, b);
      op_reg32: exp_val = alu(w[14:12], alt, 1'b1, a, b);
      default: begin
        // ebreak, the only system word the generator emits
        exp_we = 1'b0;
        ends = 1'b1;
      end
    endcase
    if (exp_rd == 5'd0) exp_we = 1'b0;
    if (exp_we) xr[exp_rd] = exp_val;
    mpc = npc;
  endtask

  task automatic end_with_failure();
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    run = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  endtask

  // run is low here, so nothing may retire and pc sits at 0
  task automatic check_stopped();
    check_equal(64'(retire_valid), 64'd0, "retire_valid while run is low");
    check_equal(retire.pc, 64'd0, "pc while run is low");
    check_equal(64'(halted), 64'd0, "halted after reset");
    check_equal(64'(trap), 64'd0, "trap after reset");
  endtask

  task automatic load_program();
    for (int i = 0; i < prog_len; i++) begin
      @(negedge clk);
      prog_we   = 1'b1;
      prog_addr = i[7:0];
      prog_data = prog[i[7:0]];
      // outputs settle well before the next rising edge
      #1;
      check_stopped();
    end
    @(negedge clk);
    prog_we = 1'b0;
  endtask

  task automatic run_program(input logic expect_trap);
    int          cycles;
    logic        done;
    logic        exp_we;
    logic [4:0]  exp_rd;
    logic [63:0] exp_val;
    mpc    = 64'd0;
    done   = 1'b0;
    cycles = 0;
    @(negedge clk);
    run = 1'b1;
    #1;
    while (!halted) begin
      if (cycles == max_cycles) begin
        $display("timeout: the core did not halt within %0d cycles", max_cycles);
        end_with_failure();
      end
      check_equal(64'(halted), 64'(done), "halted after the last instruction");
      check_equal(64'(retire_valid), 64'(prog[mpc[9:2]] != 32'd0), "retire_valid");
      if (retire_valid) begin
        check_equal(retire.pc, mpc, "retired pc");
        model_step(exp_we, exp_rd, exp_val, done);
        check_equal(64'(retire.rd_we), 64'(exp_we), "rd_we");
        if (exp_we) begin
          check_equal(64'(retire.rd), 64'(exp_rd), "rd");
          check_equal(retire.wdata, exp_val, "wdata");
        end
      end else begin
        // zero word, the model stops without retiring it
        done = 1'b1;
      end
      @(negedge clk);
      #1;
      cycles++;
    end
    check_equal(64'(done), 64'd1, "halted before the program ended");
    check_equal(64'(trap), 64'(expect_trap), "trap");
    repeat (3) begin
      @(negedge clk);
      #1;
      check_equal(64'(retire_valid), 64'd0, "retire_valid after halt");
      check_equal(64'(halted), 64'd1, "halted stays set");
    end
  endtask

  initial begin
    rst       = 1'b1;
    run       = 1'b0;
    prog_we   = 1'b0;
    prog_addr = 8'd0;
    prog_data = 32'd0;
    seed      = 32'h8b2b;
    xr[0]     = 64'd0;
    apply_reset();
    repeat (3) begin
      @(negedge clk);
      #1;
      check_stopped();
    end
    // random program closed by ebreak
    gen_program(1'b1, 150, ebreak_word);
    load_program();
    run_program(1'b0);
    // short program on the same state, closed by an invalid word
    apply_reset();
    gen_program(1'b0, 12, 32'h0000_0000);
    load_program();
    run_program(1'b1);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== compile.f ====
rtl/rv_isa_pkg.sv
rtl/core_cfg_pkg.sv
rtl/idu.sv
rtl/regfile.sv
rtl/exu.sv
rtl/data_mem.sv
rtl/core_top.sv
dv/tb_clk.sv
dv/core_tb.sv

// ==== Makefile ====
TOP = core_tb

.PHONY: all lint clean

# build, run, and pass only if the pass line shows up in the output
all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

obj_dir/V$(TOP): compile.f $(shell cat compile.f)
	verilator --binary --assert -j 0 --top-module $(TOP) -f compile.f

lint:
	verilator --lint-only -Wall --top-module core_top $(shell grep '^rtl/' compile.f)

clean:
	rm -rf obj_dir
